// ==== include/icache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// address and instruction word widths
`define ICACHE_ADDR_W           32
`define ICACHE_XLEN             64

// sets and address split (tag 31..11, index 10..5, offset 4..0)
`define ICACHE_SETS             64
`define ICACHE_INDEX_W          6
`define ICACHE_OFFSET_W         5
`define ICACHE_TAG_W            21

// one line is four beats of one word each
`define ICACHE_LINE_BEATS       4
`define ICACHE_LINE_W           256
`define ICACHE_SRAM_W           128
`define ICACHE_LEN_W            8

// top address nibble of the uncached region
`define ICACHE_UNCACHED_NIBBLE  4'd3

`endif

// ==== list.f ====
+incdir+include
logic/icachePkg.sv
logic/icacheSram.sv
logic/icacheReqStage.sv
logic/icacheTagStore.sv
logic/icacheCtrl.sv
logic/icacheRefill.sv
logic/icacheTop.sv
test/icacheMemModel.sv
test/icacheTb.sv

// ==== logic/icacheCtrl.sv ====
`include "icache_cfg.svh"

module icacheCtrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           valid_i,
    input  logic                           stallN_i,
    input  icachePkg::fetchReq_t           req_i,
    input  logic [1:0]                     hitWay_i,
    input  logic                           uncachedHit_i,
    input  logic                           victimWay_i,
    input  logic                           lineDone_i,
    input  icachePkg::lineBuf_t            line_i,
    input  logic [1:0][`ICACHE_LINE_W-1:0] wayData_i,
    output logic                           take_o,
    output logic [3:0]                     sramCen_o,
    output logic [3:0]                     sramWen_o,
    output icachePkg::refillCmd_t          cmd_o,
    output logic                           cmdStart_o,
    output logic                           fill_o,
    output icachePkg::fetchResp_t          resp_o
);

    import icachePkg::*;

    typedef enum logic [2:0] {
        stIdle,
        stCompare,
        stMiss,
        stFetch,
        stReplace
    } state_t;

    state_t                  state;
    state_t                  stateNext;
    logic                    hit;
    logic                    accept;
    logic                    readEn;
    logic [1:0]              wayWrite;
    logic                    bufSel;
    logic [`ICACHE_XLEN-1:0] wayWord [2];
    logic [`ICACHE_XLEN-1:0] bufWord;

    assign hit    = |hitWay_i || uncachedHit_i;
    assign take_o = state == stIdle || (state == stCompare && hit);
    assign accept = take_o && valid_i && stallN_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                if (accept) begin
                    stateNext = stCompare;
                end
            end
            // a stalled hit stays here so the response repeats
            stCompare: begin
                if (!hit) begin
                    stateNext = stMiss;
                end else if (!accept && stallN_i) begin
                    stateNext = stIdle;
                end
            end
            stMiss: stateNext = stFetch;
            stFetch: begin
                if (lineDone_i) begin
                    stateNext = req_i.uncached ? stCompare : stReplace;
                end
            end
            stReplace: stateNext = stCompare;
            default: stateNext = stIdle;
        endcase
    end

    // read both ways on every take, write only the victim way
    assign readEn    = take_o && valid_i;
    assign wayWrite  = state != stReplace ? 2'b00 : (victimWay_i ? 2'b10 : 2'b01);
    assign sramWen_o = ~{wayWrite[1], wayWrite[1], wayWrite[0], wayWrite[0]};
    assign sramCen_o = sramWen_o & ~{4{readEn}};

    // cached misses fetch the whole aligned line, uncached ones a single word
    assign cmd_o.addr = req_i.uncached ? {req_i.addr[`ICACHE_ADDR_W-1:3], 3'b000}
                                       : {req_i.tag, req_i.index, {`ICACHE_OFFSET_W{1'b0}}};
    assign cmd_o.len  = req_i.uncached ? '0 : `ICACHE_LEN_W'(`ICACHE_LINE_BEATS - 1);
    assign cmdStart_o = state == stMiss;
    assign fill_o     = state == stReplace || (state == stFetch && lineDone_i && req_i.uncached);

    // sram data is stale right after a fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bufSel <= 1'b0;
        end else if (fill_o) begin
            bufSel <= 1'b1;
        end else if (stallN_i) begin
            bufSel <= 1'b0;
        end
    end

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayWord[w] = wayData_i[w][req_i.wordSel * `ICACHE_XLEN +: `ICACHE_XLEN];
        end
        bufWord = req_i.uncached ? line_i.beat[0] : line_i.beat[req_i.wordSel];
    end

    assign resp_o.dataOk    = state == stCompare && hit;
    assign resp_o.dataNotOk = (state == stCompare && !hit) || state == stMiss
                              || state == stFetch || state == stReplace;
    assign resp_o.data      = bufSel ? bufWord : (hitWay_i[1] ? wayWord[1] : wayWord[0]);

    // a line is only written for a cached request that missed in both ways
    lineWriteOnMiss: assert property (@(posedge clk) disable iff (!rst_n)
        sramWen_o != 4'hf |-> !req_i.uncached && hitWay_i == 2'b00);

endmodule

// ==== logic/icachePkg.sv ====
`include "icache_cfg.svh"

package icachePkg;

    // request as latched by the input stage
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0]  addr;
        logic [`ICACHE_INDEX_W-1:0] index;
        logic [`ICACHE_TAG_W-1:0]   tag;
        // word within the line
        logic [1:0]                 wordSel;
        logic                       uncached;
    } fetchReq_t;

    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tagEntry_t;

    // len is beats minus one
    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [`ICACHE_LEN_W-1:0]  len;
    } refillCmd_t;

    // beat 0 holds the lowest address
    typedef struct packed {
        logic [`ICACHE_LINE_BEATS-1:0][`ICACHE_XLEN-1:0] beat;
    } lineBuf_t;

    typedef struct packed {
        logic                    dataOk;
        logic                    dataNotOk;
        logic [`ICACHE_XLEN-1:0] data;
    } fetchResp_t;

endpackage

// ==== logic/icacheRefill.sv ====
`include "icache_cfg.svh"

module icacheRefill (
    input  logic                      clk,
    input  logic                      rst_n,
    input  icachePkg::refillCmd_t     cmd_i,
    input  logic                      cmdStart_i,
    input  logic                      memRdReady_i,
    input  logic [`ICACHE_XLEN-1:0]   memData_i,
    input  logic                      memDataValid_i,
    input  logic                      memRdLast_i,
    output logic                      memRdValid_o,
    output logic [`ICACHE_ADDR_W-1:0] memAddr_o,
    output logic [`ICACHE_LEN_W-1:0]  memRdLen_o,
    output icachePkg::lineBuf_t       line_o,
    output logic                      lineDone_o
);

    import icachePkg::*;

    refillCmd_t cmdQ;
    lineBuf_t   lineQ;
    logic       pending;
    logic       busy;
    logic       beatIn;
    logic [$clog2(`ICACHE_LINE_BEATS)-1:0] beatCnt;

    // read goes out on the first cycle with ready, possibly the start cycle
    assign memRdValid_o = (cmdStart_i || pending) && memRdReady_i;
    assign memAddr_o    = cmdStart_i ? cmd_i.addr : cmdQ.addr;
    assign memRdLen_o   = cmdStart_i ? cmd_i.len : cmdQ.len;

    always_ff @(posedge clk) begin
        if (cmdStart_i) begin
            cmdQ <= cmd_i;
        end
    end

    assign beatIn     = busy && memDataValid_i;
    assign lineDone_o = beatIn && memRdLast_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            busy    <= 1'b0;
            beatCnt <= '0;
        end else begin
            if (memRdValid_o) begin
                pending <= 1'b0;
            end else if (cmdStart_i) begin
                pending <= 1'b1;
            end
            if (memRdValid_o) begin
                busy <= 1'b1;
            end else if (lineDone_o) begin
                busy <= 1'b0;
            end
            // wraps back to beat 0 after last
            if (beatIn) begin
                beatCnt <= memRdLast_i ? '0 : beatCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beatIn) begin
            lineQ.beat[beatCnt] <= memData_i;
        end
    end

    assign line_o = lineQ;

    lastOnBeat: assert property (@(posedge clk) disable iff (!rst_n)
        memRdLast_i |-> memDataValid_i && busy);

endmodule

// ==== logic/icacheReqStage.sv ====
`include "icache_cfg.svh"

module icacheReqStage (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`ICACHE_ADDR_W-1:0]  addr_i,
    input  logic                       valid_i,
    input  logic                       stallN_i,
    input  logic                       take_i,
    output icachePkg::fetchReq_t       req_o,
    output logic [`ICACHE_INDEX_W-1:0] sramIndex_o
);

    import icachePkg::*;

    fetchReq_t reqD;
    fetchReq_t reqQ;
    logic      accept;

    // controller says it can take one, core must be valid and not stalled
    assign accept = take_i && valid_i && stallN_i;

    // split the incoming address
    always_comb begin
        reqD.addr     = addr_i;
        reqD.index    = addr_i[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
        reqD.tag      = addr_i[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        reqD.wordSel  = addr_i[`ICACHE_OFFSET_W-1 -: 2];
        reqD.uncached = addr_i[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNCACHED_NIBBLE;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reqQ <= '0;
        end else if (accept) begin
            reqQ <= reqD;
        end
    end

    assign req_o = reqQ;

    // sram looks at the new index only while a request goes in
    // stall and line write both keep the latched one
    assign sramIndex_o = accept ? reqD.index : reqQ.index;

endmodule

// ==== logic/icacheSram.sv ====
`include "icache_cfg.svh"

module icacheSram (
    input  logic                       clk,
    input  logic                       cen_i,
    input  logic                       wen_i,
    input  logic [`ICACHE_INDEX_W-1:0] addr_i,
    input  logic [`ICACHE_SRAM_W-1:0]  wdata_i,
    output logic [`ICACHE_SRAM_W-1:0]  rdata_o
);

    // one half line per set
    logic [`ICACHE_SRAM_W-1:0] mem [`ICACHE_SETS];

    // enables are active low
    // read data shows up the cycle after the access and then holds
    always_ff @(posedge clk) begin
        if (!cen_i) begin
            if (!wen_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

endmodule

// ==== logic/icacheTagStore.sv ====
`include "icache_cfg.svh"

module icacheTagStore (
    input  logic                 clk,
    input  logic                 rst_n,
    input  icachePkg::fetchReq_t req_i,
    input  logic                 stallN_i,
    input  logic                 clrValid_i,
    input  logic                 fill_i,
    input  logic                 fillUncached_i,
    output logic [1:0]           hitWay_o,
    output logic                 uncachedHit_o,
    output logic                 victimWay_o
);

    import icachePkg::*;

    tagEntry_t entryMem [2][`ICACHE_SETS];
    tagEntry_t entryRd  [2];
    logic      toggle;
    logic      oneShot;
    logic      lineFill;

    assign lineFill = fill_i && !fillUncached_i;

    // valid bits clear on reset and on clrValid, tags just get overwritten
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    entryMem[w][s].valid <= 1'b0;
                end
            end
        end else if (clrValid_i) begin
            for (int w = 0; w < 2; w++) begin
                for (int s = 0; s < `ICACHE_SETS; s++) begin
                    entryMem[w][s].valid <= 1'b0;
                end
            end
        end else if (lineFill) begin
            entryMem[toggle][req_i.index] <= '{valid: 1'b1, tag: req_i.tag};
        end
    end

    // compare both ways against the latched tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            entryRd[w]  = entryMem[w][req_i.index];
            hitWay_o[w] = entryRd[w].valid && entryRd[w].tag == req_i.tag && !req_i.uncached;
        end
    end

    // victim toggle flips per line fill
    // uncached hit lasts until the core moves on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            toggle  <= 1'b0;
            oneShot <= 1'b0;
        end else begin
            if (lineFill) begin
                toggle <= ~toggle;
            end
            if (fill_i && fillUncached_i) begin
                oneShot <= 1'b1;
            end else if (stallN_i) begin
                oneShot <= 1'b0;
            end
        end
    end

    assign victimWay_o   = toggle;
    assign uncachedHit_o = oneShot;

    oneWayHit: assert property (@(posedge clk) disable iff (!rst_n)
        !(hitWay_o[0] && hitWay_o[1]));

endmodule

// ==== logic/icacheTop.sv ====
`include "icache_cfg.svh"

module icacheTop (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`ICACHE_ADDR_W-1:0] addr_i,
    input  logic                      valid_i,
    input  logic                      stallN_i,
    output logic                      addrOk_o,
    output logic                      dataOk_o,
    output logic                      dataNotOk_o,
    output logic [`ICACHE_XLEN-1:0]   rdData_o,
    input  logic                      clrValid_i,
    output logic                      memRdValid_o,
    input  logic                      memRdReady_i,
    output logic [`ICACHE_LEN_W-1:0]  memRdLen_o,
    output logic [`ICACHE_ADDR_W-1:0] memAddr_o,
    input  logic [`ICACHE_XLEN-1:0]   memData_i,
    input  logic                      memDataValid_i,
    input  logic                      memRdLast_i
);

    import icachePkg::*;

    fetchReq_t                      req;
    refillCmd_t                     cmd;
    lineBuf_t                       line;
    fetchResp_t                     resp;
    logic                           take;
    logic                           cmdStart;
    logic                           lineDone;
    logic                           fill;
    logic                           uncachedHit;
    logic                           victimWay;
    logic [1:0]                     hitWay;
    logic [3:0]                     sramCen;
    logic [3:0]                     sramWen;
    logic [`ICACHE_INDEX_W-1:0]     sramIndex;
    logic [3:0][`ICACHE_SRAM_W-1:0] sramRdata;
    logic [1:0][`ICACHE_LINE_W-1:0] wayData;

    assign addrOk_o    = take;
    assign dataOk_o    = resp.dataOk;
    assign dataNotOk_o = resp.dataNotOk;
    assign rdData_o    = resp.data;

    icacheReqStage i_reqStage (
        .clk, .rst_n, .addr_i, .valid_i, .stallN_i,
        .take_i(take), .req_o(req), .sramIndex_o(sramIndex)
    );

    icacheTagStore i_tagStore (
        .clk, .rst_n, .req_i(req), .stallN_i, .clrValid_i,
        .fill_i(fill), .fillUncached_i(req.uncached),
        .hitWay_o(hitWay), .uncachedHit_o(uncachedHit), .victimWay_o(victimWay)
    );

    icacheCtrl i_ctrl (
        .clk, .rst_n, .valid_i, .stallN_i, .req_i(req),
        .hitWay_i(hitWay), .uncachedHit_i(uncachedHit), .victimWay_i(victimWay),
        .lineDone_i(lineDone), .line_i(line), .wayData_i(wayData),
        .take_o(take), .sramCen_o(sramCen), .sramWen_o(sramWen),
        .cmd_o(cmd), .cmdStart_o(cmdStart), .fill_o(fill), .resp_o(resp)
    );

    icacheRefill i_refill (
        .clk, .rst_n, .cmd_i(cmd), .cmdStart_i(cmdStart),
        .memRdReady_i, .memData_i, .memDataValid_i, .memRdLast_i,
        .memRdValid_o, .memAddr_o, .memRdLen_o,
        .line_o(line), .lineDone_o(lineDone)
    );

    // sram 2w holds the low half of way w, sram 2w+1 the high half
    for (genvar i = 0; i < 4; i++) begin : gSram
        icacheSram i_sram (
            .clk,
            .cen_i(sramCen[i]),
            .wen_i(sramWen[i]),
            .addr_i(sramIndex),
            .wdata_i({line.beat[(i % 2) * 2 + 1], line.beat[(i % 2) * 2]}),
            .rdata_o(sramRdata[i])
        );
    end

    assign wayData[0] = {sramRdata[1], sramRdata[0]};
    assign wayData[1] = {sramRdata[3], sramRdata[2]};

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the icache testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module icacheTb -Mdir build/obj -o icacheSim -f list.f \
    > build/compile.log 2>&1 || { cat build/compile.log; echo "compile error"; exit 1; }
./build/obj/icacheSim > build/sim.log 2>&1
cat build/sim.log
grep -qx "test passed" build/sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }

// ==== test/icacheMemModel.sv ====
`include "icache_cfg.svh"

module icacheMemModel (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      memRdValid_i,
    input  logic [`ICACHE_ADDR_W-1:0] memAddr_i,
    input  logic [`ICACHE_LEN_W-1:0]  memRdLen_i,
    output logic                      memRdReady_o,
    output logic [`ICACHE_XLEN-1:0]   memData_o,
    output logic                      memDataValid_o,
    output logic                      memRdLast_o
);
    timeunit 1ns;
    timeprecision 100ps;

    integer                    seed;
    int                        beats;
    int                        gap;
    logic [`ICACHE_ADDR_W-1:0] beatAddr;

    // outputs move on the falling edge
    initial begin
        seed           = 76161;
        memRdReady_o   = 1'b0;
        memData_o      = '0;
        memDataValid_o = 1'b0;
        memRdLast_o    = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && memRdValid_i && memRdReady_o) begin
                // read handshake at this rising edge
                beatAddr = memAddr_i;
                beats    = int'(memRdLen_i) + 1;
                @(negedge clk);
                memRdReady_o = 1'b0;
                for (int i = 0; i < beats; i++) begin
                    // a few idle cycles before each beat
                    gap = $random(seed) & 3;
                    repeat (gap) @(negedge clk);
                    memData_o      = {beatAddr, ~beatAddr};
                    memDataValid_o = 1'b1;
                    memRdLast_o    = i == beats - 1;
                    @(negedge clk);
                    memDataValid_o = 1'b0;
                    memRdLast_o    = 1'b0;
                    beatAddr       = beatAddr + 32'd8;
                end
            end else begin
                @(negedge clk);
                // ready is up about three cycles in four
                memRdReady_o = ($random(seed) & 3) != 0;
            end
        end
    end

endmodule

// ==== test/icacheTb.sv ====
`include "icache_cfg.svh"

module icacheTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeoutCycles = 200;

    logic                      clk;
    logic                      rst_n;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic                      valid;
    logic                      stallN;
    logic                      clrValid;
    logic                      addrOk;
    logic                      dataOk;
    logic                      dataNotOk;
    logic [`ICACHE_XLEN-1:0]   rdData;
    logic                      memRdValid;
    logic                      memRdReady;
    logic [`ICACHE_LEN_W-1:0]  memRdLen;
    logic [`ICACHE_ADDR_W-1:0] memAddr;
    logic [`ICACHE_XLEN-1:0]   memData;
    logic                      memDataValid;
    logic                      memRdLast;

    // raised by a test around a fetch that has to hit or has to miss
    logic                      expectHit;
    logic                      expectMiss;
    // last address taken by the cache and memory reads since then
    logic [`ICACHE_ADDR_W-1:0] accAddr;
    int                        reads;
    int                        errors;
    int                        errorsAtStart;
    int                        testCount;
    int                        okCount;

    icacheTop i_icacheTop (
        .clk, .rst_n,
        .addr_i(addr), .valid_i(valid), .stallN_i(stallN),
        .addrOk_o(addrOk), .dataOk_o(dataOk), .dataNotOk_o(dataNotOk), .rdData_o(rdData),
        .clrValid_i(clrValid),
        .memRdValid_o(memRdValid), .memRdReady_i(memRdReady), .memRdLen_o(memRdLen),
        .memAddr_o(memAddr), .memData_i(memData), .memDataValid_i(memDataValid),
        .memRdLast_i(memRdLast)
    );

    icacheMemModel i_memModel (
        .clk, .rst_n,
        .memRdValid_i(memRdValid), .memAddr_i(memAddr), .memRdLen_i(memRdLen),
        .memRdReady_o(memRdReady), .memData_o(memData), .memDataValid_o(memDataValid),
        .memRdLast_o(memRdLast)
    );

    // aligned address in the upper half, its inverse in the lower half
    function automatic logic [`ICACHE_XLEN-1:0] lineWord(input logic [`ICACHE_ADDR_W-1:0] a);
        logic [`ICACHE_ADDR_W-1:0] w;
        w = {a[`ICACHE_ADDR_W-1:3], 3'b000};
        return {w, ~w};
    endfunction

    function automatic logic inUncachedRegion(input logic [`ICACHE_ADDR_W-1:0] a);
        return a[`ICACHE_ADDR_W-1 -: 4] == `ICACHE_UNCACHED_NIBBLE;
    endfunction

    // one word for uncached reads, the whole line otherwise
    function automatic logic [`ICACHE_ADDR_W-1:0] memReadAddr(
            input logic [`ICACHE_ADDR_W-1:0] a);
        if (inUncachedRegion(a)) begin
            return {a[`ICACHE_ADDR_W-1:3], 3'b000};
        end
        return {a[`ICACHE_ADDR_W-1:5], 5'b00000};
    endfunction

    // length code 3 for a line, 0 for a single word
    function automatic logic [`ICACHE_LEN_W-1:0] memReadLen(input logic [`ICACHE_ADDR_W-1:0] a);
        return inUncachedRegion(a) ? `ICACHE_LEN_W'(0) : `ICACHE_LEN_W'(3);
    endfunction

    function automatic void reportMismatch(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accAddr <= '0;
            reads   <= 0;
        end else if (valid && addrOk && stallN) begin
            accAddr <= addr;
            reads   <= 0;
        end else if (memRdValid) begin
            reads <= reads + 1;
        end
    end

    resetOutputs: assert property (@(posedge clk)
        !rst_n |-> addrOk && !dataOk && !dataNotOk && !memRdValid)
        else reportMismatch("outputs not at their reset values");

    memReadShape: assert property (@(posedge clk) disable iff (!rst_n)
        memRdValid |-> memAddr == memReadAddr(accAddr) && memRdLen == memReadLen(accAddr))
        else reportMismatch("memory read address or length wrong");

    oneReadPerRequest: assert property (@(posedge clk) disable iff (!rst_n)
        memRdValid |-> reads == 0)
        else reportMismatch("more than one memory read for one request");

    responseWord: assert property (@(posedge clk) disable iff (!rst_n)
        dataOk |-> rdData == lineWord(accAddr))
        else reportMismatch("rdData_o differs from the memory word");

    hitLatency: assert property (@(posedge clk) disable iff (!rst_n)
        valid && addrOk && stallN && expectHit |=> dataOk && !dataNotOk)
        else reportMismatch("hit did not answer one cycle after acceptance");

    hitNoRead: assert property (@(posedge clk) disable iff (!rst_n)
        expectHit |-> !memRdValid)
        else reportMismatch("memory read issued on a hit");

    missDetected: assert property (@(posedge clk) disable iff (!rst_n)
        valid && addrOk && stallN && expectMiss |=> dataNotOk && !dataOk)
        else reportMismatch("expected miss was answered as a hit");

    missRefilled: assert property (@(posedge clk) disable iff (!rst_n)
        dataOk && $past(dataNotOk) |-> reads == 1)
        else reportMismatch("miss answered without exactly one memory read");

    uncachedAlwaysReads: assert property (@(posedge clk) disable iff (!rst_n)
        dataOk && inUncachedRegion(accAddr) |-> reads == 1)
        else reportMismatch("uncached word answered without a memory read");

    stallHolds: assert property (@(posedge clk) disable iff (!rst_n)
        !stallN && dataOk |=> dataOk && $stable(rdData))
        else reportMismatch("response changed while stalled");

    // request, wait for the answer, optionally freeze the pipe on it
    task automatic fetchWord(input logic [`ICACHE_ADDR_W-1:0] a, input logic hitExp,
                             input logic missExp, input int stallCycles);
        int waitCnt;
        addr       = a;
        valid      = 1'b1;
        expectHit  = hitExp;
        expectMiss = missExp;
        // addrOk_o does not follow the inputs, so it is settled here
        waitCnt = 0;
        while (!addrOk && waitCnt < timeoutCycles) begin
            @(negedge clk);
            waitCnt++;
        end
        if (!addrOk) begin
            errors++;
            $display("timeout: the cache never took the request for address %h", a);
        end else begin
            @(negedge clk);
            valid   = 1'b0;
            waitCnt = 0;
            while (!dataOk && waitCnt < timeoutCycles) begin
                @(negedge clk);
                waitCnt++;
            end
            if (!dataOk) begin
                errors++;
                $display("timeout: no dataOk_o for address %h", a);
            end else if (stallCycles > 0) begin
                // another address is offered while frozen and must be ignored
                stallN = 1'b0;
                valid  = 1'b1;
                addr   = a ^ 32'h0000_4000;
                repeat (stallCycles) @(negedge clk);
                stallN = 1'b1;
                valid  = 1'b0;
            end
        end
        valid = 1'b0;
        @(negedge clk);
        expectHit  = 1'b0;
        expectMiss = 1'b0;
    endtask

    task automatic clearCache();
        clrValid = 1'b1;
        @(negedge clk);
        clrValid = 1'b0;
        @(negedge clk);
    endtask

    task automatic closeTest(input string name);
        testCount++;
        if (errors == errorsAtStart) begin
            okCount++;
            $display("test %0d, %s: ok", testCount, name);
        end else begin
            $display("test %0d, %s: %0d errors", testCount, name, errors - errorsAtStart);
        end
        errorsAtStart = errors;
    endtask

    initial begin
        errors        = 0;
        errorsAtStart = 0;
        testCount     = 0;
        okCount       = 0;
        rst_n         = 1'b0;
        addr          = '0;
        valid         = 1'b0;
        stallN        = 1'b1;
        clrValid      = 1'b0;
        expectHit     = 1'b0;
        expectMiss    = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        fetchWord(32'h0000_2468, 1'b0, 1'b1, 0);
        closeTest("first fetch after reset refills the line");

        fetchWord(32'h0000_2470, 1'b1, 1'b0, 0);
        fetchWord(32'h0000_2460, 1'b1, 1'b0, 0);
        closeTest("same line hits without a memory read");

        // three tags on set 2
        fetchWord(32'h0001_0050, 1'b0, 1'b1, 0);
        fetchWord(32'h0001_0850, 1'b0, 1'b1, 0);
        fetchWord(32'h0001_1050, 1'b0, 1'b1, 0);
        fetchWord(32'h0001_0850, 1'b1, 1'b0, 0);
        fetchWord(32'h0001_0050, 1'b0, 1'b1, 0);
        closeTest("lines on one set alternate ways");

        fetchWord(32'h3000_1008, 1'b0, 1'b1, 0);
        fetchWord(32'h3000_1008, 1'b0, 1'b1, 0);
        closeTest("uncached word is read from memory every time");

        fetchWord(32'h0000_2478, 1'b1, 1'b0, 0);
        clearCache();
        fetchWord(32'h0000_2478, 1'b0, 1'b1, 0);
        closeTest("clear invalidates every line");

        fetchWord(32'h0000_2468, 1'b1, 1'b0, 3);
        fetchWord(32'h0000_2468, 1'b1, 1'b0, 0);
        closeTest("stall holds the response");

        $display("%0d tests, %0d ok, %0d with errors, %0d errors in total",
                 testCount, okCount, testCount - okCount, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
